//--- Makefile
TOP = tb_mips_pipe
SIM = obj_dir/V$(TOP)
SRCS = $(wildcard verilog/*.sv) $(wildcard tests/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

//--- compile.f
verilog/mips_pkg.sv
verilog/hazard_unit.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/instr_decode.sv
verilog/pipe_reg.sv
verilog/mips_pipe_top.sv
tests/tb_mips_pipe.sv

//--- tests/tb_mips_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mips_pipe;
	import mips_pkg::*;

	// mips major opcodes and r-type function codes
	localparam logic [5:0] OP_R = 6'h00;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_ADDI = 6'h08;
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;
	localparam int ACK_LIMIT = 50;
	localparam int DRAIN_LIMIT = 50;

	logic clk = 1'b0;
	logic arst_n;
	logic instr_req;
	word_t instr;
	logic instr_ack;
	logic br_valid;
	logic br_taken;
	logic wb_valid;
	reg_addr_t wb_reg;
	word_t wb_data;

	// register contents in program order
	word_t model_rf [32];
	// outstanding results, oldest first
	reg_addr_t exp_wb_reg [$];
	word_t exp_wb_data [$];
	logic exp_br [$];
	string cur_test;

	mips_pipe_top dut (
		.clk(clk), .arst_n(arst_n), .instr_req(instr_req), .instr(instr),
		.instr_ack(instr_ack), .br_valid(br_valid), .br_taken(br_taken),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	initial begin
		forever #10 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_wb(input reg_addr_t act_reg, input word_t act_data);
		reg_addr_t exp_reg;
		word_t exp_data;
		if (exp_wb_reg.size() == 0) begin
			fail_run($sformatf("%s: wb_valid for r%0d with no write outstanding",
				cur_test, act_reg));
		end else begin
			exp_reg = exp_wb_reg.pop_front();
			exp_data = exp_wb_data.pop_front();
			if (act_reg !== exp_reg) begin
				fail_run($sformatf("MISMATCH %s wb_reg expected %0d actual %0d",
					cur_test, exp_reg, act_reg));
			end else if (act_data !== exp_data) begin
				fail_run($sformatf("MISMATCH %s wb_data r%0d expected %08h actual %08h",
					cur_test, exp_reg, exp_data, act_data));
			end
		end
	endtask

	task automatic check_branch(input logic act_taken);
		logic exp_taken;
		if (exp_br.size() == 0) begin
			fail_run($sformatf("%s: br_valid with no beq outstanding", cur_test));
		end else begin
			exp_taken = exp_br.pop_front();
			if (act_taken !== exp_taken) begin
				fail_run($sformatf("MISMATCH %s br_taken expected %0b actual %0b",
					cur_test, exp_taken, act_taken));
			end
		end
	endtask

	// pre-edge values, no flop has moved yet when this reads
	always @(posedge clk) begin
		if (arst_n) begin
			if (wb_valid) begin
				check_wb(wb_reg, wb_data);
			end
			if (br_valid) begin
				check_branch(br_taken);
			end
		end
	end

	function automatic word_t enc_r(input logic [5:0] fn, input reg_addr_t rd,
			input reg_addr_t rs, input reg_addr_t rt);
		return {OP_R, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rt,
			input reg_addr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [5:0] funct_of(input int unsigned k);
		case (k % 5)
			0: return FN_ADD;
			1: return FN_SUB;
			2: return FN_AND;
			3: return FN_OR;
			default: return FN_SLT;
		endcase
	endfunction

	// raise req and wait until the core takes the word
	task automatic offer_instr(input word_t w);
		int n;
		instr = w;
		instr_req = 1'b1;
		n = 0;
		// ack held back while decode stalls
		while (!instr_ack && n < ACK_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!instr_ack) begin
			fail_run($sformatf("%s: instr_ack never rose", cur_test));
		end
	endtask

	// four-phase source, entered on a falling edge with ack low
	task automatic send_instr(input word_t w);
		int n;
		offer_instr(w);
		instr_req = 1'b0;
		n = 0;
		while (instr_ack && n < ACK_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (instr_ack) begin
			fail_run($sformatf("%s: instr_ack stuck high after req dropped", cur_test));
		end
	endtask

	// r0 writes leave no trace
	task automatic expect_write(input reg_addr_t rd, input word_t y);
		if (rd != 5'd0) begin
			model_rf[rd] = y;
			exp_wb_reg.push_back(rd);
			exp_wb_data.push_back(y);
		end
	endtask

	task automatic alu_instr(input logic [5:0] fn, input reg_addr_t rd,
			input reg_addr_t rs, input reg_addr_t rt);
		word_t a;
		word_t b;
		word_t y;
		a = model_rf[rs];
		b = model_rf[rt];
		case (fn)
			FN_ADD: y = a + b;
			FN_SUB: y = a - b;
			FN_AND: y = a & b;
			FN_OR: y = a | b;
			default: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		endcase
		expect_write(rd, y);
		send_instr(enc_r(fn, rd, rs, rt));
	endtask

	task automatic addi_instr(input reg_addr_t rt, input reg_addr_t rs,
			input logic [15:0] imm);
		// sign-extended immediate
		expect_write(rt, model_rf[rs] + {{16{imm[15]}}, imm});
		send_instr(enc_i(OP_ADDI, rt, rs, imm));
	endtask

	task automatic beq_instr(input reg_addr_t rs, input reg_addr_t rt);
		exp_br.push_back(model_rf[rs] == model_rf[rt]);
		// offset only matters to the source
		send_instr(enc_i(OP_BEQ, rt, rs, 16'h0004));
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while ((exp_wb_reg.size() != 0 || exp_br.size() != 0) && n < DRAIN_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (exp_wb_reg.size() != 0 || exp_br.size() != 0) begin
			fail_run($sformatf("%s: expected writeback or branch never arrived", cur_test));
		end
	endtask

	// reset also clears the register file
	task automatic pulse_reset();
		arst_n = 1'b0;
		instr_req = 1'b0;
		exp_wb_reg.delete();
		exp_wb_data.delete();
		exp_br.delete();
		for (int i = 0; i < 32; i++) begin
			model_rf[i] = '0;
		end
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
	endtask

	task automatic addi_chain();
		int k;
		word_t r;
		cur_test = "addi_chain";
		for (k = 1; k <= 8; k++) begin
			r = $urandom;
			addi_instr(reg_addr_t'(k), reg_addr_t'(k - 1), r[15:0]);
		end
		wait_drain();
	endtask

	task automatic forward_chain();
		int k;
		word_t r;
		reg_addr_t prev;
		reg_addr_t prev2;
		reg_addr_t dst;
		cur_test = "forward_chain";
		r = $urandom;
		addi_instr(5'd10, 5'd0, r[15:0]);
		r = $urandom;
		addi_instr(5'd11, 5'd0, r[15:0]);
		prev2 = 5'd10;
		prev = 5'd11;
		// each op reads the two most recent results
		for (k = 0; k < 12; k++) begin
			dst = reg_addr_t'(12 + k % 4);
			r = $urandom;
			alu_instr(funct_of(r), dst, prev, prev2);
			prev2 = prev;
			prev = dst;
		end
		// both operands from one producer
		alu_instr(FN_ADD, 5'd16, prev, prev);
		alu_instr(FN_SUB, 5'd17, 5'd16, 5'd16);
		alu_instr(FN_SLT, 5'd17, 5'd17, 5'd16);
		wait_drain();
	endtask

	task automatic zero_reg();
		cur_test = "zero_reg";
		addi_instr(5'd0, 5'd1, 16'h7fff);
		alu_instr(FN_ADD, 5'd0, 5'd1, 5'd2);
		// r0 must still read zero
		alu_instr(FN_OR, 5'd18, 5'd0, 5'd3);
		addi_instr(5'd19, 5'd0, 16'hfff0);
		beq_instr(5'd0, 5'd0);
		wait_drain();
	endtask

	task automatic beq_stall();
		cur_test = "beq_stall";
		addi_instr(5'd24, 5'd0, 16'h0042);
		beq_instr(5'd24, 5'd0);
		addi_instr(5'd25, 5'd0, 16'h0042);
		beq_instr(5'd24, 5'd25);
		alu_instr(FN_SUB, 5'd26, 5'd25, 5'd24);
		beq_instr(5'd26, 5'd0);
		wait_drain();
	endtask

	task automatic beq_forward();
		word_t r;
		cur_test = "beq_forward";
		r = $urandom;
		addi_instr(5'd27, 5'd0, r[15:0]);
		// copy, then compare against the fresh copy
		addi_instr(5'd28, 5'd27, 16'h0000);
		beq_instr(5'd28, 5'd27);
		addi_instr(5'd29, 5'd28, 16'h0001);
		beq_instr(5'd27, 5'd29);
		alu_instr(FN_AND, 5'd30, 5'd29, 5'd29);
		beq_instr(5'd30, 5'd29);
		wait_drain();
	endtask

	task automatic reset_midstream();
		cur_test = "reset_midstream";
		addi_instr(5'd20, 5'd0, 16'h0123);
		addi_instr(5'd21, 5'd20, 16'h0011);
		// beq sits in decode and r21 in the memory stage when reset hits
		offer_instr(enc_i(OP_BEQ, 5'd21, 5'd20, 16'h0004));
		pulse_reset();
		// quiet window, monitor rejects any pulse
		repeat (8) @(negedge clk);
		addi_instr(5'd22, 5'd20, 16'h0007);
		wait_drain();
	endtask

	initial begin
		void'($urandom(10823));
		arst_n = 1'b0;
		instr_req = 1'b0;
		instr = '0;
		cur_test = "reset";
		for (int i = 0; i < 32; i++) begin
			model_rf[i] = '0;
		end
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		addi_chain();
		forward_chain();
		zero_reg();
		beq_stall();
		beq_forward();
		reset_midstream();
		if (exp_wb_reg.size() == 0 && exp_br.size() == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			fail_run("results left outstanding at the end of the run");
		end
	end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input mips_pkg::alu_op_t op,
	input mips_pkg::word_t a,
	input mips_pkg::word_t b,
	output mips_pkg::word_t y
);
	import mips_pkg::*;

	logic lt;

	// signed compare for slt
	always_comb begin
		lt = $signed(a) < $signed(b);
	end

	always_comb begin
		unique case (op)
			alu_add: begin
				y = a + b;
			end
			alu_sub: begin
				y = a - b;
			end
			alu_and: begin
				y = a & b;
			end
			alu_or: begin
				y = a | b;
			end
			alu_slt: begin
				// zero-extended flag
				y = {{31{1'b0}}, lt};
			end
			default: begin
				y = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
	input mips_pkg::reg_addr_t rs_d,
	input mips_pkg::reg_addr_t rt_d,
	input logic branch_d,
	input mips_pkg::reg_addr_t rs_e,
	input mips_pkg::reg_addr_t rt_e,
	input mips_pkg::reg_addr_t writereg_e,
	input logic regwrite_e,
	input mips_pkg::reg_addr_t writereg_m,
	input logic regwrite_m,
	input mips_pkg::reg_addr_t writereg_w,
	input logic regwrite_w,
	output logic fwd_a_d,
	output logic fwd_b_d,
	output mips_pkg::fwd_e_t fwd_a_e,
	output mips_pkg::fwd_e_t fwd_b_e,
	output logic stall_d,
	output logic flush_e
);
	import mips_pkg::*;

	// true when a later stage writes src, r0 excluded
	function automatic logic hits(input reg_addr_t src, input reg_addr_t dst,
			input logic wr);
		return (src != '0) && wr && (src == dst);
	endfunction

	// execute operand source, memory stage wins over writeback
	function automatic fwd_e_t pick_e(input reg_addr_t src);
		fwd_e_t sel;
		sel = fwd_none;
		if (hits(src, writereg_m, regwrite_m)) begin
			sel = fwd_from_m;
		end else if (hits(src, writereg_w, regwrite_w)) begin
			sel = fwd_from_w;
		end
		return sel;
	endfunction

	logic dep_rs_e;
	logic dep_rt_e;

	// beq compare in decode
	// only memory stage needs a path, writeback goes through the reg file bypass
	always_comb begin
		fwd_a_d = hits(rs_d, writereg_m, regwrite_m);
		fwd_b_d = hits(rt_d, writereg_m, regwrite_m);
	end

	// alu operands in execute
	always_comb begin
		fwd_a_e = pick_e(rs_e);
		fwd_b_e = pick_e(rt_e);
	end

	// beq operand still being computed in execute
	// result not available until next cycle
	always_comb begin
		dep_rs_e = hits(rs_d, writereg_e, regwrite_e);
		dep_rt_e = hits(rt_d, writereg_e, regwrite_e);
		stall_d = branch_d && (dep_rs_e || dep_rt_e);
		// bubble into execute while decode holds
		flush_e = stall_d;
	end

endmodule

`default_nettype wire

//--- verilog/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
	input mips_pkg::word_t instr,
	output mips_pkg::reg_addr_t rs,
	output mips_pkg::reg_addr_t rt,
	output mips_pkg::reg_addr_t rd_dest,
	output mips_pkg::word_t imm,
	output mips_pkg::alu_op_t alu_op,
	output logic alu_src_imm,
	output logic reg_write,
	output logic branch
);
	import mips_pkg::*;

	// r-type function codes
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	logic [5:0] opcode;
	logic [5:0] funct;

	// fixed fields
	always_comb begin
		opcode = instr[31:26];
		funct = instr[5:0];
		rs = instr[25:21];
		rt = instr[20:16];
		imm = {{16{instr[15]}}, instr[15:0]};
	end

	always_comb begin
		// default is a no-write bubble
		rd_dest = instr[15:11];
		alu_op = alu_add;
		alu_src_imm = 1'b0;
		reg_write = 1'b0;
		branch = 1'b0;
		case (opcode)
			op_rtype: begin
				reg_write = 1'b1;
				case (funct)
					FN_ADD: alu_op = alu_add;
					FN_SUB: alu_op = alu_sub;
					FN_AND: alu_op = alu_and;
					FN_OR: alu_op = alu_or;
					FN_SLT: alu_op = alu_slt;
					// unknown funct, drop the write
					default: reg_write = 1'b0;
				endcase
			end
			op_addi: begin
				// i-type writes rt
				rd_dest = instr[20:16];
				alu_src_imm = 1'b1;
				reg_write = 1'b1;
			end
			op_beq: begin
				alu_op = alu_sub;
				branch = 1'b1;
			end
			default: begin
				reg_write = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/mips_pipe_top.sv
`timescale 1ns/1ns
`default_nettype none

module mips_pipe_top (
	input logic clk,
	input logic arst_n,
	input logic instr_req,
	input mips_pkg::word_t instr,
	output logic instr_ack,
	output logic br_valid,
	output logic br_taken,
	output logic wb_valid,
	output mips_pkg::reg_addr_t wb_reg,
	output mips_pkg::word_t wb_data
);
	import mips_pkg::*;

	// fetch register
	word_t instr_f;
	logic valid_f;
	logic take_f;

	// decode
	reg_addr_t rs_d, rt_d, dst_d;
	word_t imm_d, rd1_d, rd2_d, cmp_a_d, cmp_b_d;
	alu_op_t alu_op_d;
	logic alu_src_imm_d, reg_write_d, is_beq_d, branch_d;
	logic fwd_a_d, fwd_b_d, stall_d, flush_e;

	// execute, memory, writeback
	id_ex_t id_ex_d, id_ex_q;
	ex_mem_t ex_mem_d, ex_mem_q;
	mem_wb_t mem_wb_d, mem_wb_q;
	logic ex_valid, mem_valid, wb_stage_valid;
	logic regwrite_e, regwrite_m, regwrite_w;
	fwd_e_t fwd_a_e, fwd_b_e;
	word_t src_a_e, src_b_e, alu_b_e, alu_y_e;

	// accept a word when req is up, ack is down and decode can move
	assign take_f = instr_req && !instr_ack && !stall_d;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			instr_ack <= 1'b0;
			valid_f <= 1'b0;
		end else begin
			if (take_f) begin
				instr_ack <= 1'b1;
			end else if (!instr_req) begin
				instr_ack <= 1'b0;
			end
			// empties once decode hands the word to execute
			if (take_f) begin
				valid_f <= 1'b1;
			end else if (!stall_d) begin
				valid_f <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_f) begin
			instr_f <= instr;
		end
	end

	instr_decode u_dec (
		.instr(instr_f), .rs(rs_d), .rt(rt_d), .rd_dest(dst_d), .imm(imm_d),
		.alu_op(alu_op_d), .alu_src_imm(alu_src_imm_d), .reg_write(reg_write_d),
		.branch(is_beq_d)
	);

	reg_file u_rf (
		.clk(clk), .arst_n(arst_n), .ra1(rs_d), .ra2(rt_d),
		.we(regwrite_w), .wa(mem_wb_q.dst), .wd(mem_wb_q.result),
		.rd1(rd1_d), .rd2(rd2_d)
	);

	// stage write enables only count with a valid instruction
	assign branch_d = valid_f && is_beq_d;
	assign regwrite_e = ex_valid && id_ex_q.reg_write;
	assign regwrite_m = mem_valid && ex_mem_q.reg_write;
	assign regwrite_w = wb_stage_valid && mem_wb_q.reg_write;

	hazard_unit u_haz (
		.rs_d(rs_d), .rt_d(rt_d), .branch_d(branch_d),
		.rs_e(id_ex_q.rs), .rt_e(id_ex_q.rt),
		.writereg_e(id_ex_q.dst), .regwrite_e(regwrite_e),
		.writereg_m(ex_mem_q.dst), .regwrite_m(regwrite_m),
		.writereg_w(mem_wb_q.dst), .regwrite_w(regwrite_w),
		.fwd_a_d(fwd_a_d), .fwd_b_d(fwd_b_d), .fwd_a_e(fwd_a_e), .fwd_b_e(fwd_b_e),
		.stall_d(stall_d), .flush_e(flush_e)
	);

	// beq resolved here, memory-stage value forwarded in
	assign cmp_a_d = fwd_a_d ? ex_mem_q.result : rd1_d;
	assign cmp_b_d = fwd_b_d ? ex_mem_q.result : rd2_d;
	assign br_valid = branch_d && !stall_d;
	assign br_taken = (cmp_a_d == cmp_b_d);

	assign id_ex_d = '{a: rd1_d, b: rd2_d, imm: imm_d, rs: rs_d, rt: rt_d, dst: dst_d,
		alu_op: alu_op_d, alu_src_imm: alu_src_imm_d, reg_write: reg_write_d};

	pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clk(clk), .arst_n(arst_n), .hold(1'b0), .flush(flush_e),
		.d_valid(valid_f), .d(id_ex_d), .q_valid(ex_valid), .q(id_ex_q)
	);

	// operand muxes
	always_comb begin
		unique case (fwd_a_e)
			fwd_from_m: src_a_e = ex_mem_q.result;
			fwd_from_w: src_a_e = mem_wb_q.result;
			default: src_a_e = id_ex_q.a;
		endcase
		unique case (fwd_b_e)
			fwd_from_m: src_b_e = ex_mem_q.result;
			fwd_from_w: src_b_e = mem_wb_q.result;
			default: src_b_e = id_ex_q.b;
		endcase
		// addi takes the immediate
		alu_b_e = id_ex_q.alu_src_imm ? id_ex_q.imm : src_b_e;
	end

	alu u_alu (.op(id_ex_q.alu_op), .a(src_a_e), .b(alu_b_e), .y(alu_y_e));

	assign ex_mem_d = '{result: alu_y_e, dst: id_ex_q.dst, reg_write: id_ex_q.reg_write};

	pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
		.clk(clk), .arst_n(arst_n), .hold(1'b0), .flush(1'b0),
		.d_valid(ex_valid), .d(ex_mem_d), .q_valid(mem_valid), .q(ex_mem_q)
	);

	// no data memory, result passes straight on
	assign mem_wb_d = '{result: ex_mem_q.result, dst: ex_mem_q.dst,
		reg_write: ex_mem_q.reg_write};

	pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
		.clk(clk), .arst_n(arst_n), .hold(1'b0), .flush(1'b0),
		.d_valid(mem_valid), .d(mem_wb_d), .q_valid(wb_stage_valid), .q(mem_wb_q)
	);

	// retire, r0 writes stay silent
	assign wb_valid = regwrite_w && (mem_wb_q.dst != '0);
	assign wb_reg = mem_wb_q.dst;
	assign wb_data = mem_wb_q.result;

	// a stall bubbles execute and clears itself the next cycle
	a_stall_bubble: assert property (@(posedge clk) disable iff (!arst_n)
		stall_d |=> (!ex_valid && !stall_d));

endmodule

`default_nettype wire

//--- verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

	// data word and register number
	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// major opcode field, bits 31:26
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_beq = 6'h04,
		op_addi = 6'h08
	} opcode_t;

	// alu function select
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_t;

	// execute operand source
	// 00 register file, 01 writeback, 10 memory stage
	typedef enum logic [1:0] {
		fwd_none = 2'b00,
		fwd_from_w = 2'b01,
		fwd_from_m = 2'b10
	} fwd_e_t;

	// decode to execute
	typedef struct packed {
		word_t a;
		word_t b;
		word_t imm;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dst;
		alu_op_t alu_op;
		logic alu_src_imm;
		logic reg_write;
	} id_ex_t;

	// execute to memory
	typedef struct packed {
		word_t result;
		reg_addr_t dst;
		logic reg_write;
	} ex_mem_t;

	// memory to writeback, same layout
	typedef struct packed {
		word_t result;
		reg_addr_t dst;
		logic reg_write;
	} mem_wb_t;

endpackage

`default_nettype wire

//--- verilog/pipe_reg.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic arst_n,
	input logic hold,
	input logic flush,
	input logic d_valid,
	input payload_t d,
	output logic q_valid,
	output payload_t q
);

	// stage occupancy
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q_valid <= 1'b0;
		end else if (flush) begin
			q_valid <= 1'b0;
		end else if (!hold) begin
			q_valid <= d_valid;
		end
	end

	// payload only meaningful with q_valid
	always_ff @(posedge clk) begin
		if (!hold) begin
			q <= d;
		end
	end

	// parent must never hold and bubble the same stage
	a_hold_flush: assert property (@(posedge clk) disable iff (!arst_n) !(hold && flush));

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input logic clk,
	input logic arst_n,
	input mips_pkg::reg_addr_t ra1,
	input mips_pkg::reg_addr_t ra2,
	input logic we,
	input mips_pkg::reg_addr_t wa,
	input mips_pkg::word_t wd,
	output mips_pkg::word_t rd1,
	output mips_pkg::word_t rd2
);
	import mips_pkg::*;

	// entry 0 never written
	word_t regs [32];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	// write-through so decode sees the writeback value this cycle
	always_comb begin
		if (ra1 == '0) begin
			rd1 = '0;
		end else if (we && (wa == ra1)) begin
			rd1 = wd;
		end else begin
			rd1 = regs[ra1];
		end
		if (ra2 == '0) begin
			rd2 = '0;
		end else if (we && (wa == ra2)) begin
			rd2 = wd;
		end else begin
			rd2 = regs[ra2];
		end
	end

endmodule

`default_nettype wire
